/* include/ldtu_macros.svh */
// ########################################
// Front-end data path constants
// Widths, FIFO depth and register map
// ########################################

`ifndef LDTU_MACROS_SVH
`define LDTU_MACROS_SVH

// ADC sample and baseline widths
`define LDTU_SAMPLE_W 12
`define LDTU_BSL_W 8

// Serializer word and FIFO depth in words
`define LDTU_WORD_W 32
`define LDTU_FIFO_DEPTH 8

// Resync code bits after the start bit
`define LDTU_CMD_W 4

// Wishbone register map
`define LDTU_WB_ADR_W 3
`define LDTU_REG_MODE 3'd0
`define LDTU_REG_BSL 3'd1
`define LDTU_REG_SAT 3'd2
`define LDTU_REG_PATTERN 3'd3
`define LDTU_REG_TPLEN 3'd4
`define LDTU_REG_STATUS 3'd5

`endif

/* design/ldtuPkg.sv */
// ########################################
// Shared types of the digitizer data path
// Enums for modes and commands, bus structs
// ########################################

`include "ldtu_macros.svh"

package ldtuPkg;

	// Gain choice per sample pair
	typedef enum logic [1:0] {
		gainAuto      = 2'd0,
		gainForceHigh = 2'd1,
		gainForceLow  = 2'd2
	} gainModeT;

	// Codes carried by a resync frame
	typedef enum logic [`LDTU_CMD_W-1:0] {
		cmdNop       = 4'd0,
		cmdDtuReset  = 4'd1,
		cmdAdcReset  = 4'd2,
		cmdAdcCal    = 4'd3,
		cmdSyncStart = 4'd4,
		cmdSyncStop  = 4'd5,
		cmdFlush     = 4'd6,
		cmdBc0       = 4'd7,
		cmdTestPulse = 4'd8,
		cmdPllLock   = 4'd9
	} resyncCmdT;

	// Header of an output word
	typedef enum logic [1:0] {
		typeData = 2'd1,
		typeSync = 2'd2,
		typeBc0  = 2'd3
	} wordTypeT;

	// Processed sample, lowGain set for the low-gain ADC
	typedef struct packed {
		logic                      lowGain;
		logic [`LDTU_SAMPLE_W-1:0] value;
	} sampleT;

	// Configuration as seen by the data path
	typedef struct packed {
		gainModeT                  gainMode;
		logic [`LDTU_BSL_W-1:0]    bslHigh;
		logic [`LDTU_BSL_W-1:0]    bslLow;
		logic [`LDTU_SAMPLE_W-1:0] satValue;
		logic [`LDTU_WORD_W-1:0]   smPattern;
		logic [7:0]                tpLength;
	} dtuCfgT;

	// Decoded resync actions towards the frame builder
	typedef struct packed {
		logic clear;
		logic syncMode;
		logic bc0;
	} dtuCtrlT;

	// Wishbone classic request and response
	typedef struct packed {
		logic                      cyc;
		logic                      stb;
		logic                      we;
		logic [`LDTU_WB_ADR_W-1:0] adr;
		logic [`LDTU_WORD_W-1:0]   datW;
	} wbReqT;

	typedef struct packed {
		logic                    ack;
		logic [`LDTU_WORD_W-1:0] datR;
	} wbRspT;

endpackage

/* design/ldtuConfigRegs.sv */
// ########################################
// Configuration registers
// Wishbone classic slave, one-cycle ack
// ########################################

`include "ldtu_macros.svh"

module ldtuConfigRegs (
	input  logic            ClkIn,
	input  logic            arstN,
	input  ldtuPkg::wbReqT  wbReq,
	output ldtuPkg::wbRspT  wbRsp,
	input  logic            dtuLoss,
	output ldtuPkg::dtuCfgT dtuCfg
);

	ldtuPkg::gainModeT         modeQ;
	logic [2*`LDTU_BSL_W-1:0]  bslQ;
	logic [`LDTU_SAMPLE_W-1:0] satQ;
	logic [`LDTU_WORD_W-1:0]   patternQ;
	logic [7:0]                tpLenQ;
	logic                      ackQ;
	logic [`LDTU_WORD_W-1:0]   datRQ;
	logic [`LDTU_WORD_W-1:0]   rdData;
	logic                      wbActive;

	// New request, not yet acknowledged
	assign wbActive = wbReq.cyc & wbReq.stb & ~ackQ;

	// Control registers, written on the ack edge
	always_ff @(posedge ClkIn or negedge arstN) begin
		if (!arstN) begin
			ackQ     <= 1'b0;
			modeQ    <= ldtuPkg::gainAuto;
			bslQ     <= '0;
			satQ     <= '0;
			patternQ <= '0;
			tpLenQ   <= '0;
		end else begin
			ackQ <= wbActive;
			if (wbActive && wbReq.we) begin
				case (wbReq.adr)
					`LDTU_REG_MODE:    modeQ    <= ldtuPkg::gainModeT'(wbReq.datW[1:0]);
					`LDTU_REG_BSL:     bslQ     <= wbReq.datW[2*`LDTU_BSL_W-1:0];
					`LDTU_REG_SAT:     satQ     <= wbReq.datW[`LDTU_SAMPLE_W-1:0];
					`LDTU_REG_PATTERN: patternQ <= wbReq.datW;
					`LDTU_REG_TPLEN:   tpLenQ   <= wbReq.datW[7:0];
					// STATUS is read-only
					default: ;
				endcase
			end
		end
	end

	// Read mux, unused bits zero
	always_comb begin
		rdData = '0;
		case (wbReq.adr)
			`LDTU_REG_MODE:    rdData[1:0] = modeQ;
			`LDTU_REG_BSL:     rdData[2*`LDTU_BSL_W-1:0] = bslQ;
			`LDTU_REG_SAT:     rdData[`LDTU_SAMPLE_W-1:0] = satQ;
			`LDTU_REG_PATTERN: rdData = patternQ;
			`LDTU_REG_TPLEN:   rdData[7:0] = tpLenQ;
			`LDTU_REG_STATUS:  rdData[0] = dtuLoss;
			default: ;
		endcase
	end

	// Read data goes out together with ack
	always_ff @(posedge ClkIn) begin
		if (wbActive && !wbReq.we)
			datRQ <= rdData;
	end

	assign wbRsp = '{ack: ackQ, datR: datRQ};

	// High baseline in the upper byte
	assign dtuCfg = '{
		gainMode:  modeQ,
		bslHigh:   bslQ[2*`LDTU_BSL_W-1:`LDTU_BSL_W],
		bslLow:    bslQ[`LDTU_BSL_W-1:0],
		satValue:  satQ,
		smPattern: patternQ,
		tpLength:  tpLenQ
	};

endmodule

/* design/ldtuResyncDecoder.sv */
// ########################################
// Resync command decoder
// One-wire frames into pulses and levels
// ########################################

`include "ldtu_macros.svh"

module ldtuResyncDecoder (
	input  logic             ClkIn,
	input  logic             arstN,
	input  logic             ReSync,
	input  logic [7:0]       tpLength,
	output ldtuPkg::dtuCtrlT dtuCtrl,
	output logic             AdcRstN,
	output logic             AdcCal,
	output logic             PllLockStart,
	output logic             CatiaTp
);

	typedef enum logic {stIdle, stShift} stateT;

	localparam int CntW = $clog2(`LDTU_CMD_W);

	stateT                   state;
	logic                    reSyncQ;
	logic [CntW-1:0]         bitCnt;
	logic [`LDTU_CMD_W-1:0]  shiftReg;
	logic                    codeDone;
	ldtuPkg::resyncCmdT      cmd;
	logic                    clearQ;
	logic                    syncModeQ;
	logic                    bc0Q;
	logic                    adcRstNQ;
	logic                    adcCalQ;
	logic                    pllLockQ;
	logic [7:0]              tpCnt;

	// Input flop on the external line, then frame FSM
	always_ff @(posedge ClkIn or negedge arstN) begin
		if (!arstN) begin
			reSyncQ  <= 1'b1;
			state    <= stIdle;
			bitCnt   <= '0;
			codeDone <= 1'b0;
		end else begin
			reSyncQ  <= ReSync;
			codeDone <= 1'b0;
			case (state)
				stIdle: begin
					// Start bit is a low level
					if (!reSyncQ) begin
						state  <= stShift;
						bitCnt <= '0;
					end
				end
				stShift: begin
					bitCnt <= bitCnt + 1'b1;
					if (bitCnt == CntW'(`LDTU_CMD_W - 1)) begin
						state    <= stIdle;
						codeDone <= 1'b1;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// Code bits, MSB first
	always_ff @(posedge ClkIn) begin
		if (state == stShift)
			shiftReg <= {shiftReg[`LDTU_CMD_W-2:0], reSyncQ};
	end

	assign cmd = ldtuPkg::resyncCmdT'(shiftReg);

	// Command actions, one cycle after the last code bit
	always_ff @(posedge ClkIn or negedge arstN) begin
		if (!arstN) begin
			clearQ    <= 1'b0;
			syncModeQ <= 1'b0;
			bc0Q      <= 1'b0;
			adcRstNQ  <= 1'b1;
			adcCalQ   <= 1'b0;
			pllLockQ  <= 1'b0;
			tpCnt     <= '0;
		end else begin
			clearQ   <= 1'b0;
			bc0Q     <= 1'b0;
			adcRstNQ <= 1'b1;
			adcCalQ  <= 1'b0;
			pllLockQ <= 1'b0;
			// Test pulse runs down
			if (tpCnt != '0)
				tpCnt <= tpCnt - 1'b1;
			if (codeDone) begin
				case (cmd)
					ldtuPkg::cmdDtuReset: begin
						clearQ    <= 1'b1;
						syncModeQ <= 1'b0;
					end
					ldtuPkg::cmdAdcReset:  adcRstNQ  <= 1'b0;
					ldtuPkg::cmdAdcCal:    adcCalQ   <= 1'b1;
					ldtuPkg::cmdSyncStart: syncModeQ <= 1'b1;
					ldtuPkg::cmdSyncStop:  syncModeQ <= 1'b0;
					ldtuPkg::cmdFlush:     clearQ    <= 1'b1;
					ldtuPkg::cmdBc0:       bc0Q      <= 1'b1;
					// Zero length gives no pulse
					ldtuPkg::cmdTestPulse: tpCnt     <= tpLength;
					ldtuPkg::cmdPllLock:   pllLockQ  <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	assign dtuCtrl      = '{clear: clearQ, syncMode: syncModeQ, bc0: bc0Q};
	assign AdcRstN      = adcRstNQ;
	assign AdcCal       = adcCalQ;
	assign PllLockStart = pllLockQ;
	assign CatiaTp      = (tpCnt != '0);

endmodule

/* design/ldtuGainSelect.sv */
// ########################################
// Gain selector
// Gain choice, baseline subtraction, clamp
// ########################################

`include "ldtu_macros.svh"

module ldtuGainSelect (
	input  logic                      ClkIn,
	input  logic                      arstN,
	input  logic                      AdcValid,
	input  logic [`LDTU_SAMPLE_W-1:0] AdcDoutH,
	input  logic [`LDTU_SAMPLE_W-1:0] AdcDoutL,
	input  ldtuPkg::dtuCfgT           dtuCfg,
	output ldtuPkg::sampleT           sample,
	output logic                      sampleValid
);

	ldtuPkg::sampleT next;

	always_comb begin
		logic [`LDTU_SAMPLE_W-1:0] raw;
		logic [`LDTU_SAMPLE_W-1:0] bsl;

		case (dtuCfg.gainMode)
			ldtuPkg::gainForceHigh: next.lowGain = 1'b0;
			ldtuPkg::gainForceLow:  next.lowGain = 1'b1;
			// Auto, high gain until it saturates
			default:                next.lowGain = (AdcDoutH >= dtuCfg.satValue);
		endcase
		raw = next.lowGain ? AdcDoutL : AdcDoutH;
		bsl = next.lowGain ? `LDTU_SAMPLE_W'(dtuCfg.bslLow) : `LDTU_SAMPLE_W'(dtuCfg.bslHigh);
		// Clamp below baseline to zero
		next.value = (raw >= bsl) ? raw - bsl : '0;
	end

	always_ff @(posedge ClkIn or negedge arstN) begin
		if (!arstN)
			sampleValid <= 1'b0;
		else
			sampleValid <= AdcValid;
	end

	always_ff @(posedge ClkIn) begin
		if (AdcValid)
			sample <= next;
	end

endmodule

/* design/ldtuFrameBuilder.sv */
// ########################################
// Frame builder and output FIFO
// Packs sample pairs, serves the serializer
// ########################################

`include "ldtu_macros.svh"

module ldtuFrameBuilder (
	input  logic                    ClkIn,
	input  logic                    arstN,
	input  ldtuPkg::sampleT         sample,
	input  logic                    sampleValid,
	input  ldtuPkg::dtuCtrlT        dtuCtrl,
	input  logic [`LDTU_WORD_W-1:0] smPattern,
	input  logic                    DtuHshake,
	output logic [`LDTU_WORD_W-1:0] DataOut,
	output logic                    DataValid,
	output logic                    DtuLoss
);

	localparam int PtrW = $clog2(`LDTU_FIFO_DEPTH);
	localparam int PadW = `LDTU_WORD_W - 2 - 2 * $bits(ldtuPkg::sampleT);

	logic [`LDTU_WORD_W-1:0] mem [`LDTU_FIFO_DEPTH];
	logic [PtrW-1:0]         wrPtr;
	logic [PtrW-1:0]         rdPtr;
	logic [PtrW:0]           count;
	ldtuPkg::sampleT         halfSample;
	logic                    halfValid;
	logic                    bc0Pend;
	logic [`LDTU_WORD_W-1:0] wordQ;
	logic                    wordValidQ;
	logic                    lossQ;
	ldtuPkg::wordTypeT       wordType;
	logic                    wordDone;
	logic                    full;
	logic                    empty;
	logic                    push;
	logic                    pop;

	// Second sample of a pair, ignored in sync mode
	assign wordDone = sampleValid & halfValid & ~dtuCtrl.syncMode;
	// Marker also counts in its own cycle
	assign wordType = (bc0Pend | dtuCtrl.bc0) ? ldtuPkg::typeBc0 : ldtuPkg::typeData;

	assign full  = (count == (PtrW+1)'(`LDTU_FIFO_DEPTH));
	assign empty = (count == '0);
	// FIFO frozen while the pattern is sent
	assign pop   = DtuHshake & ~empty & ~dtuCtrl.syncMode;
	// A full FIFO still takes a word if the head leaves
	assign push  = wordValidQ & (~full | pop);

	always_ff @(posedge ClkIn or negedge arstN) begin
		if (!arstN) begin
			halfValid  <= 1'b0;
			bc0Pend    <= 1'b0;
			wordValidQ <= 1'b0;
			wrPtr      <= '0;
			rdPtr      <= '0;
			count      <= '0;
			lossQ      <= 1'b0;
		end else if (dtuCtrl.clear) begin
			// Flush, pending half word dropped too
			halfValid  <= 1'b0;
			bc0Pend    <= 1'b0;
			wordValidQ <= 1'b0;
			wrPtr      <= '0;
			rdPtr      <= '0;
			count      <= '0;
			lossQ      <= 1'b0;
		end else begin
			wordValidQ <= wordDone;
			if (dtuCtrl.syncMode)
				halfValid <= 1'b0;
			else if (sampleValid)
				halfValid <= ~halfValid;
			if (wordDone)
				bc0Pend <= 1'b0;
			else if (dtuCtrl.bc0)
				bc0Pend <= 1'b1;
			if (push)
				wrPtr <= wrPtr + 1'b1;
			if (pop)
				rdPtr <= rdPtr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: ;
			endcase
			// Word lost, sticky until a clear
			if (wordValidQ && full && !pop)
				lossQ <= 1'b1;
		end
	end

	// Payload path
	always_ff @(posedge ClkIn) begin
		if (sampleValid && !halfValid)
			halfSample <= sample;
		if (wordDone)
			wordQ <= {wordType, {PadW{1'b0}}, halfSample, sample};
		if (push)
			mem[wrPtr] <= wordQ;
	end

	assign DataValid = dtuCtrl.syncMode | ~empty;
	assign DataOut   = dtuCtrl.syncMode ? smPattern : mem[rdPtr];
	assign DtuLoss   = lossQ;

endmodule

/* design/ldtuDataPath.sv */
// ########################################
// Digitizer data path top level
// Config, resync, gain select, framing
// ########################################

`include "ldtu_macros.svh"

module ldtuDataPath (
	input  logic                      ClkIn,
	input  logic                      arstN,
	input  logic                      ReSync,
	input  logic                      AdcValid,
	input  logic [`LDTU_SAMPLE_W-1:0] AdcDoutH,
	input  logic [`LDTU_SAMPLE_W-1:0] AdcDoutL,
	input  ldtuPkg::wbReqT            wbReq,
	input  logic                      DtuHshake,
	output ldtuPkg::wbRspT            wbRsp,
	output logic                      AdcRstN,
	output logic                      AdcCal,
	output logic                      PllLockStart,
	output logic                      CatiaTp,
	output logic [`LDTU_WORD_W-1:0]   DataOut,
	output logic                      DataValid,
	output logic                      DtuLoss
);

	ldtuPkg::dtuCfgT  dtuCfg;
	ldtuPkg::dtuCtrlT dtuCtrl;
	ldtuPkg::sampleT  sample;
	logic             sampleValid;

	// Registers, loss flag read back in STATUS
	ldtuConfigRegs i_configRegs (
		.ClkIn   (ClkIn),
		.arstN   (arstN),
		.wbReq   (wbReq),
		.wbRsp   (wbRsp),
		.dtuLoss (DtuLoss),
		.dtuCfg  (dtuCfg)
	);

	ldtuResyncDecoder i_resyncDecoder (
		.ClkIn        (ClkIn),
		.arstN        (arstN),
		.ReSync       (ReSync),
		.tpLength     (dtuCfg.tpLength),
		.dtuCtrl      (dtuCtrl),
		.AdcRstN      (AdcRstN),
		.AdcCal       (AdcCal),
		.PllLockStart (PllLockStart),
		.CatiaTp      (CatiaTp)
	);

	ldtuGainSelect i_gainSelect (
		.ClkIn       (ClkIn),
		.arstN       (arstN),
		.AdcValid    (AdcValid),
		.AdcDoutH    (AdcDoutH),
		.AdcDoutL    (AdcDoutL),
		.dtuCfg      (dtuCfg),
		.sample      (sample),
		.sampleValid (sampleValid)
	);

	// Serializer side uses the plain handshake
	ldtuFrameBuilder i_frameBuilder (
		.ClkIn       (ClkIn),
		.arstN       (arstN),
		.sample      (sample),
		.sampleValid (sampleValid),
		.dtuCtrl     (dtuCtrl),
		.smPattern   (dtuCfg.smPattern),
		.DtuHshake   (DtuHshake),
		.DataOut     (DataOut),
		.DataValid   (DataValid),
		.DtuLoss     (DtuLoss)
	);

endmodule

/* tests/ldtuDataPath_chk.sv */
// ########################################
// Bound checks on the data path
// Wishbone ack, reset state, output hold
// ########################################

`include "ldtu_macros.svh"

module ldtuDataPath_chk (
	input logic                    ClkIn,
	input logic                    arstN,
	input ldtuPkg::wbReqT          wbReq,
	input ldtuPkg::wbRspT          wbRsp,
	input logic                    DataValid,
	input logic                    CatiaTp,
	input logic                    DtuHshake,
	input logic [`LDTU_WORD_W-1:0] DataOut
);

	// Ack is a single-cycle pulse
	ackOnce: assert property (@(posedge ClkIn) disable iff (!arstN)
		wbRsp.ack |=> !wbRsp.ack) else $error("ack longer than one cycle");

	// Ack only answers an active request
	ackReq: assert property (@(posedge ClkIn) disable iff (!arstN)
		wbRsp.ack |-> $past(wbReq.cyc && wbReq.stb)) else $error("ack without request");

	// Quiet outputs when reset ends
	rstState: assert property (@(posedge ClkIn)
		$rose(arstN) |-> (!DataValid && !CatiaTp)) else $error("outputs active after reset");

	// Head word held until taken
	holdOut: assert property (@(posedge ClkIn) disable iff (!arstN)
		(DataValid && !DtuHshake) |=> (!DataValid || $stable(DataOut)))
		else $error("DataOut changed while waiting");

endmodule

bind ldtuDataPath ldtuDataPath_chk i_chk (
	.ClkIn     (ClkIn),
	.arstN     (arstN),
	.wbReq     (wbReq),
	.wbRsp     (wbRsp),
	.DataValid (DataValid),
	.CatiaTp   (CatiaTp),
	.DtuHshake (DtuHshake),
	.DataOut   (DataOut)
);

/* tests/ldtuDataPath_tb.sv */
// ########################################
// Data path testbench
// Table-driven stimulus with a word model
// ########################################

`include "ldtu_macros.svh"

module ldtuDataPath_tb;

	typedef enum {opWrite, opRead, opPair, opCmd, opPull, opPort} opKindT;
	typedef struct {
		opKindT      kind;
		logic [31:0] adr;
		logic [31:0] data;
		logic [31:0] exp;
	} opT;

	logic ClkIn;
	logic arstN;
	logic ReSync;
	logic AdcValid;
	logic [`LDTU_SAMPLE_W-1:0] AdcDoutH;
	logic [`LDTU_SAMPLE_W-1:0] AdcDoutL;
	ldtuPkg::wbReqT wbReq;
	logic DtuHshake;
	ldtuPkg::wbRspT wbRsp;
	logic AdcRstN;
	logic AdcCal;
	logic PllLockStart;
	logic CatiaTp;
	logic [`LDTU_WORD_W-1:0] DataOut;
	logic DataValid;
	logic DtuLoss;

	// Model of the configuration and the FIFO contents
	logic [1:0]  mMode;
	logic [7:0]  mBslH;
	logic [7:0]  mBslL;
	logic [11:0] mSat;
	logic [31:0] mPattern;
	logic [7:0]  mTpLen;
	logic        mBc0;
	logic        mSync;
	logic [31:0] expQ[$];
	opT          opList[$];
	integer      seed = 68;
	int          cycles = 0;
	int          cycleLimit = 100000;

	ldtuDataPath i_ldtuDataPath (.*);

	initial ClkIn = 1'b0;
	always #20 ClkIn = ~ClkIn;

	always @(posedge ClkIn) begin
		cycles <= cycles + 1;
		if (cycles > cycleLimit)
			stopOnError("simulation ran past its cycle limit");
	end

	task automatic stopOnError(input string msg);
		$display("%s", msg);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
			stopOnError("value mismatch");
		end
	endtask

	// Gain choice, baseline and clamp on one raw pair
	function automatic logic [12:0] refSample(input logic [11:0] h, input logic [11:0] l);
		logic        low;
		logic [11:0] raw;
		logic [11:0] bsl;
		low = (mMode == 2'd1) ? 1'b0 : (mMode == 2'd2) ? 1'b1 : (h >= mSat);
		raw = low ? l : h;
		bsl = low ? {4'd0, mBslL} : {4'd0, mBslH};
		return {low, (raw >= bsl) ? raw - bsl : 12'd0};
	endfunction

	task automatic addOp(input opKindT k, input logic [31:0] a, input logic [31:0] d,
		input logic [31:0] e);
		opList.push_back('{kind: k, adr: a, data: d, exp: e});
	endtask

	task automatic busXfer(input logic we, input logic [2:0] adr, input logic [31:0] d,
		input logic [31:0] exp);
		int n;
		@(posedge ClkIn);
		wbReq <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, datW: d};
		n = 0;
		do begin
			@(negedge ClkIn);
			n++;
			if (n > 10)
				stopOnError("no Wishbone ack");
		end while (!wbRsp.ack);
		if (!we)
			checkEq("wbRsp.datR", wbRsp.datR, exp);
		@(posedge ClkIn);
		wbReq <= '0;
		@(negedge ClkIn);
		checkEq("wbRsp.ack", {31'd0, wbRsp.ack}, 32'd0);
	endtask

	task automatic samplePair();
		logic [11:0] h[2];
		logic [11:0] l[2];
		logic [12:0] s[2];
		for (int i = 0; i < 2; i++) begin
			h[i] = $random(seed);
			l[i] = $random(seed);
			s[i] = refSample(h[i], l[i]);
			@(posedge ClkIn);
			AdcValid <= 1'b1;
			AdcDoutH <= h[i];
			AdcDoutL <= l[i];
		end
		@(posedge ClkIn);
		AdcValid <= 1'b0;
		// Let the word land in the FIFO
		repeat (3) @(posedge ClkIn);
		if (!mSync) begin
			if (expQ.size() < `LDTU_FIFO_DEPTH)
				expQ.push_back({mBc0 ? 2'd3 : 2'd1, 4'd0, s[0], s[1]});
			mBc0 = 1'b0;
		end
	endtask

	task automatic resyncCmd(input logic [3:0] code);
		string pulseName[4] = '{"AdcRstN", "AdcCal", "PllLockStart", "CatiaTp"};
		int cnt[4];
		int first[4];
		int expCnt[4];
		logic hit[4];
		@(posedge ClkIn);
		ReSync <= 1'b0;
		for (int i = 3; i >= 0; i--) begin
			@(posedge ClkIn);
			ReSync <= code[i];
		end
		@(posedge ClkIn);
		ReSync <= 1'b1;
		for (int k = 0; k < 4; k++) begin
			cnt[k] = 0;
			first[k] = 0;
		end
		// Negedge after the stop edge is index 5, action expected at 7
		for (int idx = 5; idx < 29; idx++) begin
			@(negedge ClkIn);
			hit[0] = !AdcRstN;
			hit[1] = AdcCal;
			hit[2] = PllLockStart;
			hit[3] = CatiaTp;
			for (int k = 0; k < 4; k++) begin
				if (hit[k] && cnt[k] == 0)
					first[k] = idx;
				if (hit[k])
					cnt[k]++;
			end
		end
		expCnt[0] = (code == 4'd2);
		expCnt[1] = (code == 4'd3);
		expCnt[2] = (code == 4'd9);
		expCnt[3] = (code == 4'd8) ? mTpLen : 0;
		for (int k = 0; k < 4; k++) begin
			checkEq($sformatf("%s cycles", pulseName[k]), cnt[k], expCnt[k]);
			if (expCnt[k] != 0)
				checkEq($sformatf("%s start", pulseName[k]), first[k], 7);
		end
		case (code)
			4'd1, 4'd6: begin
				expQ.delete();
				mBc0 = 1'b0;
				if (code == 4'd1)
					mSync = 1'b0;
			end
			4'd4: mSync = 1'b1;
			4'd5: mSync = 1'b0;
			4'd7: mBc0 = 1'b1;
			default: ;
		endcase
	endtask

	task automatic pullWord();
		int n;
		logic [31:0] exp;
		n = 0;
		do begin
			@(negedge ClkIn);
			n++;
			if (n > 20)
				stopOnError("DataValid never rose for an expected word");
		end while (!DataValid);
		if (mSync)
			exp = mPattern;
		else if (expQ.size() == 0)
			stopOnError("word present when the model expects none");
		else
			exp = expQ.pop_front();
		checkEq("DataOut", DataOut, exp);
		@(posedge ClkIn);
		DtuHshake <= 1'b1;
		@(posedge ClkIn);
		DtuHshake <= 1'b0;
	endtask

	task automatic buildTable();
		addOp(opWrite, 0, 0, 0);
		addOp(opWrite, 1, 32'hFFFF_4020, 0);
		addOp(opWrite, 2, 32'h800, 0);
		addOp(opWrite, 3, 32'hA5C3_0F96, 0);
		addOp(opWrite, 4, 5, 0);
		addOp(opWrite, 5, 1, 0);
		addOp(opRead, 1, 0, 32'h4020);
		addOp(opRead, 2, 0, 32'h800);
		addOp(opRead, 3, 0, 32'hA5C3_0F96);
		addOp(opRead, 4, 0, 5);
		addOp(opRead, 5, 0, 0);
		for (int m = 0; m < 3; m++) begin
			addOp(opWrite, 0, m, 0);
			addOp(opRead, 0, 0, m);
			repeat (3) addOp(opPair, 0, 0, 0);
			repeat (3) addOp(opPull, 0, 0, 0);
		end
		addOp(opWrite, 0, 0, 0);
		addOp(opCmd, 0, 7, 0);
		repeat (2) addOp(opPair, 0, 0, 0);
		repeat (2) addOp(opPull, 0, 0, 0);
		addOp(opCmd, 0, 4, 0);
		repeat (2) addOp(opPull, 0, 0, 0);
		addOp(opPair, 0, 0, 0);
		addOp(opPull, 0, 0, 0);
		addOp(opCmd, 0, 5, 0);
		addOp(opPair, 0, 0, 0);
		addOp(opPull, 0, 0, 0);
		repeat (10) addOp(opPair, 0, 0, 0);
		addOp(opPort, 0, 0, 32'd3);
		addOp(opRead, 5, 0, 1);
		repeat (8) addOp(opPull, 0, 0, 0);
		addOp(opPort, 0, 0, 32'd1);
		addOp(opCmd, 0, 6, 0);
		addOp(opPort, 0, 0, 32'd0);
		addOp(opCmd, 0, 8, 0);
		addOp(opWrite, 4, 0, 0);
		addOp(opCmd, 0, 8, 0);
		addOp(opCmd, 0, 2, 0);
		addOp(opCmd, 0, 3, 0);
		addOp(opCmd, 0, 9, 0);
	endtask

	function automatic int opCycles(input opKindT k);
		case (k)
			opWrite, opRead: return 5;
			opPair:          return 6;
			opCmd:           return 30;
			opPull:          return 23;
			default:         return 2;
		endcase
	endfunction

	initial begin
		int total;
		arstN = 1'b0;
		ReSync = 1'b1;
		AdcValid = 1'b0;
		AdcDoutH = '0;
		AdcDoutL = '0;
		wbReq = '0;
		DtuHshake = 1'b0;
		{mMode, mBslH, mBslL, mSat, mPattern, mTpLen, mBc0, mSync} = '0;
		buildTable();
		total = 0;
		foreach (opList[i])
			total += opCycles(opList[i].kind);
		cycleLimit = 2 * total + 200;
		repeat (5) @(posedge ClkIn);
		arstN <= 1'b1;
		foreach (opList[i]) begin
			case (opList[i].kind)
				opWrite: begin
					busXfer(1'b1, opList[i].adr[2:0], opList[i].data, 0);
					case (opList[i].adr)
						0: mMode = opList[i].data[1:0];
						1: {mBslH, mBslL} = opList[i].data[15:0];
						2: mSat = opList[i].data[11:0];
						3: mPattern = opList[i].data;
						4: mTpLen = opList[i].data[7:0];
						default: ;
					endcase
				end
				opRead: busXfer(1'b0, opList[i].adr[2:0], 0, opList[i].exp);
				opPair: samplePair();
				opCmd:  resyncCmd(opList[i].data[3:0]);
				opPull: pullWord();
				default: begin
					@(negedge ClkIn);
					checkEq("DataValid", {31'd0, DataValid}, {31'd0, opList[i].exp[1]});
					checkEq("DtuLoss", {31'd0, DtuLoss}, {31'd0, opList[i].exp[0]});
				end
			endcase
		end
		if (expQ.size() == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			stopOnError("words left unread at the end");
		end
	end

endmodule

/* ldtuDataPath.f */
+incdir+include
design/ldtuPkg.sv
design/ldtuConfigRegs.sv
design/ldtuResyncDecoder.sv
design/ldtuGainSelect.sv
design/ldtuFrameBuilder.sv
design/ldtuDataPath.sv
tests/ldtuDataPath_chk.sv
tests/ldtuDataPath_tb.sv

/* run.sh */
#!/bin/sh
# Build with Verilator and run the data path testbench
out=$(verilator --binary --timing --assert -Wno-fatal \
	-f ldtuDataPath.f --top-module ldtuDataPath_tb -o simv \
	&& ./obj_dir/simv) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -q "TESTS PASSED" || exit 1
